//--- verilog/dp_defines.svh
`ifndef DP_DEFINES_SVH
`define DP_DEFINES_SVH

// Data path and instruction word width
`define DP_WORD_W   32

// Architectural registers, R15 included
`define DP_NUM_REGS 16
`define DP_ADDR_W   4

// Fetch address after reset
`define DP_RESET_PC 32'h0000_0000

`endif

//--- verilog/arm_isa_pkg.sv
`include "dp_defines.svh"

package arm_isa_pkg;

    // Data word, also used for a whole instruction
    typedef logic [`DP_WORD_W-1:0] word_t;

    typedef logic [`DP_ADDR_W-1:0] reg_addr_t; // Register number R0..R15

    // Data-processing opcode field, bits 24:21
    typedef enum logic [3:0] {
        op_and = 4'b0000,
        op_eor = 4'b0001,
        op_sub = 4'b0010,
        op_add = 4'b0100,
        op_cmp = 4'b1010,
        op_orr = 4'b1100,
        op_mov = 4'b1101
    } dp_opcode_t;

endpackage

//--- verilog/dp_ctrl_pkg.sv
package dp_ctrl_pkg;

    typedef logic [2:0] alu_op_t; // ALU function select

    localparam alu_op_t alu_pass_b = 3'd0; // MOV
    localparam alu_op_t alu_and    = 3'd1;
    localparam alu_op_t alu_eor    = 3'd2;
    localparam alu_op_t alu_or     = 3'd3;
    localparam alu_op_t alu_add    = 3'd4;
    localparam alu_op_t alu_sub    = 3'd5; // SUB and CMP

    // N Z C V, N in the top bit
    typedef logic [3:0] flags_t;

    localparam int unsigned flag_n = 3;
    localparam int unsigned flag_z = 2;
    localparam int unsigned flag_c = 1;
    localparam int unsigned flag_v = 0;

endpackage

//--- verilog/register_file.sv
`timescale 1ns/1ns
`include "dp_defines.svh"

module register_file(clk, rst_n, a_1, a_2, a_3, wd_3, r_15, we_3, rd_1, rd_2);

    input  logic                   clk;
    input  logic                   rst_n;
    input  arm_isa_pkg::reg_addr_t a_1;
    input  arm_isa_pkg::reg_addr_t a_2;
    input  arm_isa_pkg::reg_addr_t a_3;
    input  arm_isa_pkg::word_t     wd_3;
    input  arm_isa_pkg::word_t     r_15;
    input  logic                   we_3;

    output arm_isa_pkg::word_t     rd_1;
    output arm_isa_pkg::word_t     rd_2;

    // Index of the PC register
    localparam arm_isa_pkg::reg_addr_t pc_reg = `DP_ADDR_W'(`DP_NUM_REGS - 1);

    arm_isa_pkg::word_t regs [`DP_NUM_REGS]; // R0..R15
    logic               write_gp;            // Write port hits R0..R14

    // R15 is owned by the PC path, the write port never reaches it
    assign write_gp = we_3 && (a_3 != pc_reg);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `DP_NUM_REGS - 1; i++) begin
                regs[i] <= '0;
            end
            regs[pc_reg] <= `DP_RESET_PC + `DP_WORD_W'(8); // Reset PC plus 8
        end else begin
            if (write_gp) begin
                regs[a_3] <= wd_3; // ALU write-back
            end
            regs[pc_reg] <= r_15; // Loaded every cycle
        end
    end

    // Two independent read muxes
    assign rd_1 = regs[a_1];
    assign rd_2 = regs[a_2];

endmodule

//--- verilog/instr_decode.sv
`timescale 1ns/1ns
`include "dp_defines.svh"

module instr_decode(clk, rst_n, instr, instr_valid, a_1, a_2, a_3, we_3, r_15, imm,
                    use_imm, alu_op, set_flags, illegal, pc);

    input  logic                   clk;
    input  logic                   rst_n;
    input  arm_isa_pkg::word_t     instr;
    input  logic                   instr_valid;

    output arm_isa_pkg::reg_addr_t a_1;
    output arm_isa_pkg::reg_addr_t a_2;
    output arm_isa_pkg::reg_addr_t a_3;
    output logic                   we_3;
    output arm_isa_pkg::word_t     r_15;
    output arm_isa_pkg::word_t     imm;
    output logic                   use_imm;
    output dp_ctrl_pkg::alu_op_t   alu_op;
    output logic                   set_flags;
    output logic                   illegal;
    output arm_isa_pkg::word_t     pc;

    localparam arm_isa_pkg::reg_addr_t pc_reg = `DP_ADDR_W'(`DP_NUM_REGS - 1);

    arm_isa_pkg::dp_opcode_t opcode;
    logic                    s_bit;
    logic                    supported;
    arm_isa_pkg::word_t      next_pc;

    // Instruction fields
    assign use_imm = instr[25];                              // I bit
    assign opcode  = arm_isa_pkg::dp_opcode_t'(instr[24:21]);
    assign s_bit   = instr[20];
    assign a_1     = instr[19:16];                           // Rn
    assign a_3     = instr[15:12];                           // Rd
    assign a_2     = instr[3:0];                             // Rm
    assign imm     = {{(`DP_WORD_W - 8){1'b0}}, instr[7:0]}; // No rotation

    always_comb begin
        supported = 1'b1;
        case (opcode)
            arm_isa_pkg::op_and: alu_op = dp_ctrl_pkg::alu_and;
            arm_isa_pkg::op_eor: alu_op = dp_ctrl_pkg::alu_eor;
            arm_isa_pkg::op_sub: alu_op = dp_ctrl_pkg::alu_sub;
            arm_isa_pkg::op_add: alu_op = dp_ctrl_pkg::alu_add;
            arm_isa_pkg::op_cmp: alu_op = dp_ctrl_pkg::alu_sub; // Subtract, flags only
            arm_isa_pkg::op_orr: alu_op = dp_ctrl_pkg::alu_or;
            arm_isa_pkg::op_mov: alu_op = dp_ctrl_pkg::alu_pass_b;
            default: begin
                supported = 1'b0;
                alu_op    = dp_ctrl_pkg::alu_pass_b;
            end
        endcase
    end

    assign illegal = instr_valid && !supported;

    // No write for CMP and none to the PC
    assign we_3 = instr_valid && supported && (opcode != arm_isa_pkg::op_cmp)
                  && (a_3 != pc_reg);

    assign set_flags = instr_valid && supported && (s_bit || (opcode == arm_isa_pkg::op_cmp));

    // PC steps only on a valid instruction
    assign next_pc = instr_valid ? pc + `DP_WORD_W'(4) : pc;
    assign r_15    = next_pc + `DP_WORD_W'(8); // R15 view after the edge

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `DP_RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ns
`include "dp_defines.svh"

module alu(clk, rst_n, rd_1, rd_2, imm, use_imm, alu_op, set_flags, result, wd_3, flags);

    input  logic                 clk;
    input  logic                 rst_n;
    input  arm_isa_pkg::word_t   rd_1;
    input  arm_isa_pkg::word_t   rd_2;
    input  arm_isa_pkg::word_t   imm;
    input  logic                 use_imm;
    input  dp_ctrl_pkg::alu_op_t alu_op;
    input  logic                 set_flags;

    output arm_isa_pkg::word_t   result;
    output arm_isa_pkg::word_t   wd_3;
    output dp_ctrl_pkg::flags_t  flags;

    localparam int unsigned msb = `DP_WORD_W - 1;

    arm_isa_pkg::word_t   op_b;
    arm_isa_pkg::word_t   b_eff;      // Inverted for subtract
    logic [`DP_WORD_W:0]  sum_full;   // Carry in the top bit
    logic                 is_sub;
    logic                 is_arith;
    arm_isa_pkg::word_t   res;
    dp_ctrl_pkg::flags_t  flags_next;

    assign op_b     = use_imm ? imm : rd_2;
    assign is_sub   = (alu_op == dp_ctrl_pkg::alu_sub);
    assign is_arith = is_sub || (alu_op == dp_ctrl_pkg::alu_add);
    assign b_eff    = is_sub ? ~op_b : op_b;
    assign sum_full = {1'b0, rd_1} + {1'b0, b_eff} + {{`DP_WORD_W{1'b0}}, is_sub};

    always_comb begin
        case (alu_op)
            dp_ctrl_pkg::alu_pass_b: res = op_b;
            dp_ctrl_pkg::alu_and:    res = rd_1 & op_b;
            dp_ctrl_pkg::alu_eor:    res = rd_1 ^ op_b;
            dp_ctrl_pkg::alu_or:     res = rd_1 | op_b;
            dp_ctrl_pkg::alu_add,
            dp_ctrl_pkg::alu_sub:    res = sum_full[msb:0];
            default:                 res = '0;
        endcase
    end

    always_comb begin
        flags_next = flags; // Logic ops keep C and V
        flags_next[dp_ctrl_pkg::flag_n] = res[msb];
        flags_next[dp_ctrl_pkg::flag_z] = (res == '0);
        if (is_arith) begin
            // Carry out, which is the inverted borrow for SUB
            flags_next[dp_ctrl_pkg::flag_c] = sum_full[`DP_WORD_W];
            flags_next[dp_ctrl_pkg::flag_v] = (rd_1[msb] == b_eff[msb]) && (res[msb] != rd_1[msb]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (set_flags) begin
            flags <= flags_next;
        end
    end

    assign wd_3   = res; // Write-back data
    assign result = res;

endmodule

//--- verilog/dp_core.sv
`timescale 1ns/1ns
`include "dp_defines.svh"

module dp_core(clk, rst_n, instr, instr_valid, result, flags, pc, illegal);

    input  logic                clk;
    input  logic                rst_n;
    input  arm_isa_pkg::word_t  instr;
    input  logic                instr_valid;

    output arm_isa_pkg::word_t  result;
    output dp_ctrl_pkg::flags_t flags;
    output arm_isa_pkg::word_t  pc;
    output logic                illegal;

    arm_isa_pkg::reg_addr_t a_1;
    arm_isa_pkg::reg_addr_t a_2;
    arm_isa_pkg::reg_addr_t a_3;
    logic                   we_3;
    arm_isa_pkg::word_t     r_15;   // Next PC plus 8
    arm_isa_pkg::word_t     imm;
    logic                   use_imm;
    dp_ctrl_pkg::alu_op_t   alu_op;
    logic                   set_flags;
    arm_isa_pkg::word_t     rd_1;
    arm_isa_pkg::word_t     rd_2;
    arm_isa_pkg::word_t     wd_3;   // Write-back word

    // Decoder and register file side by side
    instr_decode instr_decode_inst (.clk(clk), .rst_n(rst_n),
                                    .instr(instr), .instr_valid(instr_valid),
                                    .a_1(a_1), .a_2(a_2), .a_3(a_3), .we_3(we_3),
                                    .r_15(r_15), .imm(imm), .use_imm(use_imm),
                                    .alu_op(alu_op), .set_flags(set_flags),
                                    .illegal(illegal), .pc(pc));

    register_file register_file_inst (.clk(clk), .rst_n(rst_n),
                                      .a_1(a_1), .a_2(a_2), .a_3(a_3),
                                      .wd_3(wd_3), .r_15(r_15), .we_3(we_3),
                                      .rd_1(rd_1), .rd_2(rd_2));

    // ALU joins both, result loops back as wd_3
    alu alu_inst (.clk(clk), .rst_n(rst_n),
                  .rd_1(rd_1), .rd_2(rd_2), .imm(imm), .use_imm(use_imm),
                  .alu_op(alu_op), .set_flags(set_flags),
                  .result(result), .wd_3(wd_3), .flags(flags));

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen(clk);

    parameter int period = 100; // ns

    output logic clk;

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

//--- bench/dp_core_asserts.sv
`timescale 1ns/1ns
`include "dp_defines.svh"

module dp_core_asserts(clk, rst_n, we_3, a_3, illegal, instr_valid, pc);

    input logic                   clk;
    input logic                   rst_n;
    input logic                   we_3;
    input arm_isa_pkg::reg_addr_t a_3;
    input logic                   illegal;
    input logic                   instr_valid;
    input arm_isa_pkg::word_t     pc;

    localparam arm_isa_pkg::reg_addr_t pc_reg = `DP_ADDR_W'(`DP_NUM_REGS - 1);

    // Register file write port never aims at R15
    no_pc_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(we_3 && (a_3 == pc_reg)))
        else $error("Register file write enabled with R15 as destination");

    illegal_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> instr_valid)
        else $error("illegal raised without a valid instruction");

    pc_steps: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |=> (pc == $past(pc) + 32'd4))
        else $error("PC did not advance by 4 after a valid instruction");

    pc_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_valid |=> (pc == $past(pc)))
        else $error("PC moved in a cycle without a valid instruction");

endmodule

// we_3 and a_3 are the register file's write port nets inside dp_core
bind dp_core dp_core_asserts dp_core_asserts_inst (.clk(clk), .rst_n(rst_n), .we_3(we_3),
                                                   .a_3(a_3), .illegal(illegal),
                                                   .instr_valid(instr_valid), .pc(pc));

//--- bench/dp_core_tb.sv
`timescale 1ns/1ns
`include "dp_defines.svh"

module dp_core_tb;

    localparam int clk_period    = 100;
    localparam int drive_delay   = 5;
    localparam int reset_cycles  = 10;
    localparam int reset_timeout = 50; // Cycles

    typedef struct packed {
        arm_isa_pkg::word_t  ins;
        logic                valid;
        arm_isa_pkg::word_t  exp_res;
        logic                chk_res;   // Result is undefined for unsupported opcodes
        dp_ctrl_pkg::flags_t exp_flags; // Flags left by the earlier rows
        logic                exp_ill;
        arm_isa_pkg::word_t  exp_pc;
    } row_t;

    logic                clk;
    logic                rst_n;
    arm_isa_pkg::word_t  instr;
    logic                instr_valid;
    arm_isa_pkg::word_t  result;
    dp_ctrl_pkg::flags_t flags;
    arm_isa_pkg::word_t  pc;
    logic                illegal;

    row_t                rows[$];
    arm_isa_pkg::word_t  model_regs [`DP_NUM_REGS - 1]; // R0..R14, R15 follows the PC
    arm_isa_pkg::word_t  model_pc;
    dp_ctrl_pkg::flags_t model_flags;
    logic [15:0]         lfsr_state;
    int                  errors;
    int                  checks;

    tb_clock_gen #(.period(clk_period)) tb_clock_gen_inst (.clk(clk));

    dp_core dp_core_inst (.clk(clk), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
                          .result(result), .flags(flags), .pc(pc), .illegal(illegal));

    // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [7:0] next_rand_byte();
        logic [7:0] b;
        for (int n = 0; n < 8; n++) begin
            b[n]       = lfsr_state[0];
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return b;
    endfunction

    // Data-processing word, cond AL, op2 is imm8 or Rm with no shift
    function automatic arm_isa_pkg::word_t encode(input logic [3:0] opc, input logic s,
                                                  input logic i, input int rn, input int rd,
                                                  input int op2);
        encode = {4'hE, 2'b00, i, opc, s, 4'(rn), 4'(rd), 4'h0, 8'(op2)};
    endfunction

    function automatic arm_isa_pkg::word_t model_read(input int n);
        if (n == `DP_NUM_REGS - 1) begin
            model_read = model_pc + 32'd8;
        end else begin
            model_read = model_regs[n];
        end
    endfunction

    // Expected outputs for one instruction, then the model state update
    task automatic add_row(input arm_isa_pkg::word_t ins, input logic valid);
        row_t               r;
        logic [3:0]         opc;
        arm_isa_pkg::word_t a;
        arm_isa_pkg::word_t b;
        arm_isa_pkg::word_t res;
        logic [32:0]        wide;
        logic               ok;
        logic               c;
        logic               v;
        opc = ins[24:21];
        a   = model_read(int'(ins[19:16]));
        b   = ins[25] ? {24'h0, ins[7:0]} : model_read(int'(ins[3:0]));
        ok  = 1'b1;
        c   = model_flags[1]; // Logic ops keep C and V
        v   = model_flags[0];
        case (opc)
            arm_isa_pkg::op_and: res = a & b;
            arm_isa_pkg::op_eor: res = a ^ b;
            arm_isa_pkg::op_orr: res = a | b;
            arm_isa_pkg::op_mov: res = b;
            arm_isa_pkg::op_add: begin
                wide = {1'b0, a} + {1'b0, b};
                res  = wide[31:0];
                c    = wide[32];
                v    = (a[31] == b[31]) && (res[31] != a[31]);
            end
            arm_isa_pkg::op_sub, arm_isa_pkg::op_cmp: begin
                res = a - b;
                c   = (a >= b); // No borrow
                v   = (a[31] != b[31]) && (res[31] != a[31]);
            end
            default: begin
                res = 32'd0;
                ok  = 1'b0;
            end
        endcase
        r.ins       = ins;
        r.valid     = valid;
        r.exp_res   = res;
        r.chk_res   = ok;
        r.exp_flags = model_flags;
        r.exp_ill   = valid && !ok;
        r.exp_pc    = model_pc;
        rows.push_back(r);
        if (valid) begin
            model_pc = model_pc + 32'd4;
            if (ok && (opc != arm_isa_pkg::op_cmp) && (ins[15:12] != 4'hF)) begin
                model_regs[ins[15:12]] = res;
            end
            if (ok && (ins[20] || (opc == arm_isa_pkg::op_cmp))) begin
                model_flags = {res[31], (res == 32'd0), c, v};
            end
        end
    endtask

    task automatic build_table();
        logic [7:0] b;
        logic [3:0] opc;
        for (int k = 1; k < `DP_NUM_REGS - 1; k++) begin
            b = next_rand_byte();
            add_row(encode(arm_isa_pkg::op_mov, 1'b0, 1'b1, 0, k, int'(b)), 1'b1);
        end
        add_row(encode(arm_isa_pkg::op_mov, 1'b0, 1'b0, 0, 0, 5), 1'b1);  // R0 = R5
        add_row(encode(arm_isa_pkg::op_mov, 1'b0, 1'b0, 0, 13, 2), 1'b1); // R13 = R2
        add_row(encode(arm_isa_pkg::op_mov, 1'b0, 1'b0, 0, 12, 0), 1'b1);
        add_row(encode(arm_isa_pkg::op_add, 1'b0, 1'b0, 1, 3, 2), 1'b1);
        b = next_rand_byte();
        add_row(encode(arm_isa_pkg::op_sub, 1'b0, 1'b1, 3, 4, int'(b)), 1'b1);
        add_row(encode(arm_isa_pkg::op_and, 1'b0, 1'b0, 6, 5, 7), 1'b1);
        b = next_rand_byte();
        add_row(encode(arm_isa_pkg::op_eor, 1'b0, 1'b1, 1, 6, int'(b)), 1'b1);
        add_row(encode(arm_isa_pkg::op_orr, 1'b0, 1'b0, 2, 7, 8), 1'b1);
        b = next_rand_byte();
        add_row(encode(arm_isa_pkg::op_add, 1'b0, 1'b1, 9, 8, int'(b)), 1'b1);
        // All ones in R9, then ADDS wraps to zero with carry
        add_row(encode(arm_isa_pkg::op_sub, 1'b0, 1'b0, 10, 9, 10), 1'b1);
        add_row(encode(arm_isa_pkg::op_sub, 1'b0, 1'b1, 9, 9, 1), 1'b1);
        add_row(encode(arm_isa_pkg::op_add, 1'b1, 1'b1, 9, 10, 1), 1'b1);
        add_row(encode(arm_isa_pkg::op_mov, 1'b0, 1'b1, 0, 12, 3), 1'b1);
        add_row(encode(arm_isa_pkg::op_sub, 1'b1, 1'b1, 12, 11, 255), 1'b1);
        add_row(encode(arm_isa_pkg::op_cmp, 1'b1, 1'b0, 1, 2, 1), 1'b1); // Rd field ignored
        add_row(encode(arm_isa_pkg::op_add, 1'b0, 1'b0, 1, 13, 2), 1'b1);
        add_row(encode(arm_isa_pkg::op_orr, 1'b1, 1'b1, 13, 13, 0), 1'b1);
        // R15 reads and a suppressed R15 write
        add_row(encode(arm_isa_pkg::op_mov, 1'b0, 1'b0, 0, 0, 15), 1'b1);
        add_row(encode(arm_isa_pkg::op_mov, 1'b0, 1'b1, 0, 15, 85), 1'b1);
        add_row(encode(arm_isa_pkg::op_mov, 1'b0, 1'b0, 0, 1, 15), 1'b1);
        add_row(encode(arm_isa_pkg::op_add, 1'b0, 1'b1, 15, 2, 4), 1'b1);
        add_row(encode(arm_isa_pkg::op_mov, 1'b0, 1'b1, 0, 3, 119), 1'b0);
        add_row(encode(4'b0011, 1'b0, 1'b1, 1, 4, 17), 1'b1); // RSB is not supported
        add_row(encode(4'b1000, 1'b1, 1'b0, 2, 5, 3), 1'b1);
        add_row(encode(4'b0011, 1'b0, 1'b1, 1, 4, 17), 1'b0);
        // Traffic to R13 and R14 only
        for (int k = 0; k < 12; k++) begin
            b = next_rand_byte();
            case (k % 3)
                0: opc = arm_isa_pkg::op_add;
                1: opc = arm_isa_pkg::op_eor;
                default: opc = arm_isa_pkg::op_sub;
            endcase
            add_row(encode(opc, 1'b0, 1'b1, 13 + k % 2, 14 - k % 2, int'(b)), k != 7);
        end
        // Read back through Rm with Rd = R15, so nothing is written
        for (int k = 0; k < `DP_NUM_REGS; k++) begin
            add_row(encode(arm_isa_pkg::op_mov, 1'b0, 1'b0, 0, 15, k), 1'b1);
        end
    endtask

    task automatic check_row(input row_t r);
        if (r.chk_res) begin
            checks++;
            assert (result === r.exp_res) else begin
                errors++;
                $display("Mismatch at %0t ns: result expected %h, got %h",
                         $time, r.exp_res, result);
            end
        end
        checks += 3;
        assert (flags === r.exp_flags) else begin
            errors++;
            $display("Mismatch at %0t ns: flags expected %b, got %b", $time, r.exp_flags, flags);
        end
        assert (illegal === r.exp_ill) else begin
            errors++;
            $display("Mismatch at %0t ns: illegal expected %b, got %b", $time, r.exp_ill, illegal);
        end
        assert (pc === r.exp_pc) else begin
            errors++;
            $display("Mismatch at %0t ns: pc expected %h, got %h", $time, r.exp_pc, pc);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
    end

    initial begin
        int waited;
        instr       = 32'd0;
        instr_valid = 1'b0;
        errors      = 0;
        checks      = 0;
        lfsr_state  = 16'd55549;
        model_pc    = `DP_RESET_PC;
        model_flags = 4'd0;
        for (int k = 0; k < `DP_NUM_REGS - 1; k++) begin
            model_regs[k] = 32'd0;
        end
        build_table();
        waited = 0;
        while ((rst_n !== 1'b1) && (waited < reset_timeout)) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("Timeout: reset still active after %0d cycles", reset_timeout);
        end else begin
            foreach (rows[k]) begin
                @(posedge clk);
                #drive_delay;
                instr       = rows[k].ins;
                instr_valid = rows[k].valid;
                #(clk_period - 2 * drive_delay); // Just before the next edge
                check_row(rows[k]);
            end
            @(posedge clk);
            #drive_delay;
            instr_valid = 1'b0;
        end
        $display("Closing: %0d errors in %0d checks over %0d rows", errors, checks, rows.size());
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- dp_core.f
+incdir+verilog
verilog/arm_isa_pkg.sv
verilog/dp_ctrl_pkg.sv
verilog/register_file.sv
verilog/instr_decode.sv
verilog/alu.sv
verilog/dp_core.sv
bench/tb_clock_gen.sv
bench/dp_core_asserts.sv
bench/dp_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; the status follows the testbench verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dp_core_tb -f dp_core.f -o dp_core_sim \
    && ./obj_dir/dp_core_sim | tee /dev/stderr | grep -qx "All checks passed" \
    && { echo "Simulation PASS"; exit 0; } \
    || { echo "Simulation FAIL"; exit 1; }
